/* dv/mem_checker.sv */
module mem_checker #(
	parameter int N_PAT = 1,				// number of patterns to retire
	parameter int FIELDS = 10,				// words per pattern
	parameter int WAIT_STATES = 2				// memory wait states per access
) (
	input  logic					clk,
	input  logic					nrst,
	input  logic					i_exec_stall,
	input  logic					i_fetch_stall,
	input  logic					i_mem_stall,
	input  logic [uparc_cfg_pkg::REGNO_WIDTH-1:0]	i_rd_no,
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	i_rd_val,
	input  logic					i_bus_error,
	input  logic					i_addr_error,
	input  logic [31:0]				i_pats [N_PAT*FIELDS],
	output int					o_mismatches,
	output int					o_checks,
	output logic					o_done
);
	import uparc_cfg_pkg::*;

	int		adv_cnt;				// advancing edges seen since reset
	int		stall_cnt;				// memory stall cycles of the held item
	logic		advance;

	assign advance = !(i_exec_stall | i_fetch_stall | i_mem_stall);
	assign o_done = (o_checks == N_PAT);

	// compare the held item against pattern k as it leaves the stage
	task automatic check_retire(input int k);
		int			b;
		int			exp_stall;
		logic [REGNO_WIDTH-1:0]	exp_rd;
		b = k * FIELDS;
		exp_rd = i_pats[b][0] ? '0 : i_pats[b+1][REGNO_WIDTH-1:0];	// killed item goes to r0
		if (i_pats[b][0] || i_pats[b+2][1:0] == 2'b00)
			exp_stall = 0;					// no access issued
		else if (i_pats[b+9][0])
			exp_stall = 1;					// only the command cycle
		else
			exp_stall = WAIT_STATES + 2;			// command cycle through ack
		if (i_rd_no !== exp_rd)
		begin
			$display("MISMATCH at %0t: pattern %0d o_rd_no %0d, expected %0d",
				$time, k, i_rd_no, exp_rd);
			o_mismatches++;
		end
		if (exp_rd != '0 && i_rd_val !== i_pats[b+7])			// r0 value is unused
		begin
			$display("MISMATCH at %0t: pattern %0d o_rd_val %h, expected %h",
				$time, k, i_rd_val, i_pats[b+7]);
			o_mismatches++;
		end
		if (i_bus_error !== i_pats[b+8][0])
		begin
			$display("MISMATCH at %0t: pattern %0d o_bus_error %0b, expected %0b",
				$time, k, i_bus_error, i_pats[b+8][0]);
			o_mismatches++;
		end
		if (i_addr_error !== i_pats[b+9][0])
		begin
			$display("MISMATCH at %0t: pattern %0d o_addr_error %0b, expected %0b",
				$time, k, i_addr_error, i_pats[b+9][0]);
			o_mismatches++;
		end
		if (stall_cnt != exp_stall)
		begin
			$display("MISMATCH at %0t: pattern %0d stalled %0d cycles, expected %0d",
				$time, k, stall_cnt, exp_stall);
			o_mismatches++;
		end
		o_checks++;
	endtask

	// first advance only pushes out the reset item
	always @(posedge clk)
	begin
		if (!nrst)
		begin
			adv_cnt = 0;
			stall_cnt = 0;
			o_mismatches = 0;
			o_checks = 0;
		end
		else if (advance)
		begin
			if (adv_cnt > 0 && adv_cnt <= N_PAT)
				check_retire(adv_cnt - 1);
			adv_cnt++;
			stall_cnt = 0;				// next item starts its own count
		end
		else if (i_mem_stall)
			stall_cnt++;
	end

endmodule

/* dv/mem_patterns.txt */
// nullify rd_no op(0 idle 1 byte 2 hword 3 word) load sign_ext alu_or_addr store_data
// expected_rd_val expected_bus_error expected_addr_error
0 01 0 0 0 12345678 00000000 12345678 0 0
1 02 3 0 0 00000010 ffffffff 00000000 0 0
0 03 0 0 0 fedcba98 00000000 fedcba98 0 0
0 00 3 0 0 00000020 a5a55a5a 00000000 0 0
0 04 3 1 0 00000020 00000000 a5a55a5a 0 0
0 05 3 1 0 00000010 00000000 00000000 0 0
0 00 1 0 0 00000040 00000081 00000000 0 0
0 00 1 0 0 00000041 0000007f 00000000 0 0
0 00 1 0 0 00000042 00000002 00000000 0 0
0 00 1 0 0 00000043 000000f0 00000000 0 0
0 06 3 1 0 00000040 00000000 f0027f81 0 0
0 07 1 1 1 00000040 00000000 ffffff81 0 0
0 08 1 1 0 00000040 00000000 00000081 0 0
0 09 1 1 1 00000041 00000000 0000007f 0 0
0 0a 1 1 1 00000043 00000000 fffffff0 0 0
0 00 2 0 0 00000046 0000cafe 00000000 0 0
0 0b 2 1 1 00000046 00000000 ffffcafe 0 0
0 0c 2 1 0 00000042 00000000 0000f002 0 0
0 0d 2 1 1 00000040 00000000 00007f81 0 0
0 00 2 0 0 00000041 0000ffff 00000000 0 1
0 00 3 0 0 00000042 ffffffff 00000000 0 1
0 00 3 1 0 00000045 00000000 00000000 0 1
0 0e 3 1 0 00000040 00000000 f0027f81 0 0
0 00 3 0 0 00000400 11111111 00000000 1 0
0 0f 3 1 0 00000000 00000000 00000000 0 0
0 10 3 1 0 00000044 00000000 cafe0000 0 0
0 1f 0 0 0 0000abcd 00000000 0000abcd 0 0

/* dv/tb_mem_subsys.sv */
module tb_mem_subsys;
	import uparc_cfg_pkg::*;
	import uparc_lsu_pkg::*;

	localparam int N_PAT = 27;				// lines in the pattern file
	localparam int FIELDS = 10;				// tokens per line
	localparam int PAT_WORDS = N_PAT * FIELDS;
	localparam int TIMEOUT = 40;				// cycles allowed per wait
	localparam int RAM_WORDS = 256;
	localparam int WAIT_STATES = 2;
	localparam logic [31:0] SEED = 32'he62d_c27e;

	logic				clk;
	logic				nrst;
	logic				i_exec_stall;
	logic				i_fetch_stall;
	logic				i_nullify;
	logic				o_mem_stall;
	logic				o_bus_error;
	logic				o_addr_error;
	logic [REGNO_WIDTH-1:0]		i_rd_no;
	logic [DATA_WIDTH-1:0]		i_alu_result;
	lsu_cmd_t			i_lsu_op;
	logic				i_lsu_lns;
	logic				i_lsu_ext;
	logic [DATA_WIDTH-1:0]		i_mem_data;
	logic [REGNO_WIDTH-1:0]		o_rd_no;
	logic [DATA_WIDTH-1:0]		o_rd_val;

	logic [31:0]			pats [PAT_WORDS];	// flat pattern store
	int				mismatches;
	int				checks;
	logic				all_retired;
	logic				timed_out;
	int				setup_errs;

	uparc_mem_subsys #(
		.RAM_WORDS	(RAM_WORDS),
		.WAIT_STATES	(WAIT_STATES)
	) dut0 (.*);

	mem_checker #(
		.N_PAT		(N_PAT),
		.FIELDS		(FIELDS),
		.WAIT_STATES	(WAIT_STATES)
	) chk0 (
		.clk		(clk),
		.nrst		(nrst),
		.i_exec_stall	(i_exec_stall),
		.i_fetch_stall	(i_fetch_stall),
		.i_mem_stall	(o_mem_stall),
		.i_rd_no	(o_rd_no),
		.i_rd_val	(o_rd_val),
		.i_bus_error	(o_bus_error),
		.i_addr_error	(o_addr_error),
		.i_pats		(pats),
		.o_mismatches	(mismatches),
		.o_checks	(checks),
		.o_done		(all_retired)
	);

	always #2 clk = ~clk;					// period 4

	function automatic logic [31:0] fill_word(input int idx);
		return 32'hbad0_0000 | 32'(idx);		// unlike any real field value
	endfunction

	task automatic apply_pattern(input int k);
		int	b;
		b = k * FIELDS;
		i_nullify = pats[b][0];
		i_rd_no = pats[b+1][REGNO_WIDTH-1:0];
		i_lsu_op = lsu_cmd_t'(pats[b+2][1:0]);
		i_lsu_lns = pats[b+3][0];
		i_lsu_ext = pats[b+4][0];
		i_alu_result = pats[b+5];
		i_mem_data = pats[b+6];
	endtask

	task automatic insert_bubble;
		i_nullify = 1'b1;				// empty slot with no writeback
		i_rd_no = '0;
		i_lsu_op = LSU_IDLE;
		i_lsu_lns = 1'b0;
		i_lsu_ext = 1'b0;
	endtask

	task automatic roll_exec_stall;
		i_exec_stall = !i_exec_stall && ($urandom_range(3) == 0);	// lone stall cycles
	endtask

	// waits on falling edges until the next rising edge will advance
	task automatic issue_item(input int k, input logic bubble);
		int	n;
		logic	sent;
		n = 0;
		sent = 1'b0;
		while (!sent && n < TIMEOUT)
		begin
			roll_exec_stall();
			if (!o_mem_stall && !i_exec_stall)
			begin
				if (bubble)
					insert_bubble();
				else
					apply_pattern(k);
				sent = 1'b1;
			end
			@(negedge clk);
			n++;
		end
		if (!sent)
		begin
			$display("timeout: stage stayed stalled while issuing item %0d", k);
			timed_out = 1'b1;
		end
	endtask

	initial
	begin
		int	k;
		int	n;
		clk = 1'b0;
		nrst = 1'b0;
		i_exec_stall = 1'b0;
		i_fetch_stall = 1'b0;
		insert_bubble();
		i_alu_result = '0;
		i_mem_data = '0;
		timed_out = 1'b0;
		setup_errs = 0;
		void'($urandom(SEED));
		for (k = 0; k < PAT_WORDS; k++)
			pats[k] = fill_word(k);
		$readmemh("dv/mem_patterns.txt", pats);
		if (pats[PAT_WORDS-1] == fill_word(PAT_WORDS-1))
		begin
			$display("pattern file dv/mem_patterns.txt is missing or too short");
			setup_errs++;
		end
		repeat (3) @(negedge clk);
		nrst = 1'b1;
		for (k = 0; k < N_PAT && !timed_out && setup_errs == 0; k++)
			issue_item(k, 1'b0);
		n = 0;
		while (!all_retired && !timed_out && setup_errs == 0 && n < TIMEOUT)
		begin
			issue_item(0, 1'b1);			// bubbles push the last items out
			n++;
		end
		if (!all_retired && !timed_out && setup_errs == 0)
		begin
			$display("timeout: only %0d of %0d items retired", checks, N_PAT);
			timed_out = 1'b1;
		end
		$display("errors: %0d mismatches, %0d setup errors, %0d timeouts in %0d checks",
			mismatches, setup_errs, timed_out, checks);
		if (mismatches == 0 && setup_errs == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* hdl/uparc_cfg_pkg.sv */
package uparc_cfg_pkg;

	// core datapath sizes
	localparam int DATA_WIDTH = 32;			// data and register width
	localparam int ADDR_WIDTH = 32;			// byte address width
	localparam int REGNO_WIDTH = 5;			// destination register number, 0 is no writeback

	// memory word organisation
	localparam int BYTE_LANES = 4;			// bytes per data word
	localparam int LANE_BITS = $clog2(BYTE_LANES);	// byte offset bits inside a word
	localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - LANE_BITS;	// word index width

	// handy derived constants
	localparam int BYTE_BITS = 8;			// bits per byte lane
	localparam int HWORD_BITS = 2 * BYTE_BITS;	// bits per halfword

endpackage

/* hdl/uparc_data_ram.sv */
module uparc_data_ram #(
	parameter int RAM_WORDS = 256,		// depth in words
	parameter int WAIT_STATES = 2		// extra cycles before ack
) (
	input  logic						clk,
	input  logic						nrst,
	input  logic						ram_req,
	input  logic						ram_we,
	input  logic [uparc_cfg_pkg::WORD_ADDR_WIDTH-1:0]	ram_addr,
	input  logic [uparc_cfg_pkg::BYTE_LANES-1:0]		ram_be,
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]		ram_wdata,
	output logic						ram_ack,
	output logic [uparc_cfg_pkg::DATA_WIDTH-1:0]		ram_rdata,
	output logic						ram_err
);
	import uparc_cfg_pkg::*;

	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
	localparam int CNT_W = $clog2(WAIT_STATES + 2);

	logic [DATA_WIDTH-1:0]		mem [RAM_WORDS];
	logic [IDX_W-1:0]		idx;		// index into the array
	logic				in_range;
	logic				run_r;		// access in progress
	logic [CNT_W-1:0]		cnt_r;		// remaining wait states
	logic				err_r;		// access was out of range

	assign in_range = (ram_addr < RAM_WORDS);
	assign idx = ram_addr[IDX_W-1:0];
	assign ram_ack = run_r && (cnt_r == '0);
	assign ram_err = ram_ack & err_r;	// error rides on the ack

	// array access happens at the request edge, ack follows later
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			run_r <= 1'b0;
			cnt_r <= '0;
			err_r <= 1'b0;
			for (int w = 0; w < RAM_WORDS; w++)
				mem[w] <= '0;		// memory starts cleared
		end
		else
		begin
			if (ram_req)
			begin
				run_r <= 1'b1;
				cnt_r <= CNT_W'(WAIT_STATES);
				err_r <= !in_range;
				if (ram_we && in_range)
				begin
					for (int b = 0; b < BYTE_LANES; b++)
						if (ram_be[b])
							mem[idx][b*BYTE_BITS +: BYTE_BITS] <=
								ram_wdata[b*BYTE_BITS +: BYTE_BITS];
				end
			end
			else if (ram_ack)
				run_r <= 1'b0;		// done
			else if (run_r)
				cnt_r <= cnt_r - 1'b1;
		end
	end

	// read word, old contents on a write
	always_ff @(posedge clk)
	begin
		if (ram_req)
			ram_rdata <= in_range ? mem[idx] : '0;
	end

	// single outstanding access only
	a_no_req_while_busy: assert property (@(posedge clk) disable iff (!nrst)
		ram_req |-> !run_r)
		else $error("ram_req while an access is running");

endmodule

/* hdl/uparc_lsu.sv */
module uparc_lsu (
	input  logic						clk,
	input  logic						nrst,
	input  logic [uparc_cfg_pkg::ADDR_WIDTH-1:0]		lsu_addr,	// byte address
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]		lsu_wdata,	// store data, register view
	input  uparc_lsu_pkg::lsu_cmd_t				lsu_cmd,	// command pulse
	input  logic						lsu_rnw,	// 1 read, 0 write
	output logic [uparc_cfg_pkg::DATA_WIDTH-1:0]		lsu_rdata,	// load data at bit 0
	output logic						lsu_busy,
	output logic						lsu_err_align,
	output logic						lsu_err_bus,
	output logic						ram_req,
	output logic						ram_we,
	output logic [uparc_cfg_pkg::WORD_ADDR_WIDTH-1:0]	ram_addr,	// word index
	output logic [uparc_cfg_pkg::BYTE_LANES-1:0]		ram_be,
	output logic [uparc_cfg_pkg::DATA_WIDTH-1:0]		ram_wdata,
	input  logic						ram_ack,
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]		ram_rdata,
	input  logic						ram_err
);
	import uparc_cfg_pkg::*;
	import uparc_lsu_pkg::*;

	logic [LANE_BITS-1:0]		lane;		// byte offset inside the word
	logic [LANE_BITS-1:0]		lane_r;		// offset of the access in flight
	logic				misalign;
	logic				cmd_ok;		// aligned non-idle command
	logic				pend_r;		// waiting for ack

	assign lane = lsu_addr[LANE_BITS-1:0];
	assign ram_addr = lsu_addr[ADDR_WIDTH-1:LANE_BITS];	// drop byte offset

	// halfwords need an even address, words need lane 0
	always_comb
	begin
		case (lsu_cmd)
		LSU_HWORD: misalign = lane[0];
		LSU_WORD:  misalign = (lane != '0);
		default:   misalign = 1'b0;
		endcase
	end

	assign cmd_ok = (lsu_cmd != LSU_IDLE) && !misalign;
	assign ram_req = cmd_ok;			// misaligned never reaches memory
	assign ram_we = !lsu_rnw;
	assign lsu_busy = cmd_ok | pend_r;		// high from command until ack cycle

	// byte enables and lane replication of store data
	always_comb
	begin
		case (lsu_cmd)
		LSU_BYTE:
		begin
			ram_be = BYTE_LANES'(1) << lane;
			ram_wdata = {BYTE_LANES{lsu_wdata[BYTE_BITS-1:0]}};
		end
		LSU_HWORD:
		begin
			ram_be = BYTE_LANES'(3) << lane;	// lane is 0 or 2 here
			ram_wdata = {(BYTE_LANES/2){lsu_wdata[HWORD_BITS-1:0]}};
		end
		default:
		begin
			ram_be = '1;				// whole word
			ram_wdata = lsu_wdata;
		end
		endcase
	end

	// access tracking and error pulses
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pend_r <= 1'b0;
			lsu_err_align <= 1'b0;
			lsu_err_bus <= 1'b0;
		end
		else
		begin
			lsu_err_align <= (lsu_cmd != LSU_IDLE) && misalign;	// one cycle later
			lsu_err_bus <= ram_ack & ram_err;			// lines up with rdata
			if (ram_ack)
				pend_r <= 1'b0;
			else if (cmd_ok)
				pend_r <= 1'b1;
		end
	end

	// lane offset and returned data
	always_ff @(posedge clk)
	begin
		if (cmd_ok)
			lane_r <= lane;
		if (ram_ack)
			lsu_rdata <= ram_rdata >> {lane_r, 3'b000};	// selected lane to bit 0
	end

	// memory answers only requests that were made
	a_ack_only_when_busy: assert property (@(posedge clk) disable iff (!nrst)
		ram_ack |-> pend_r)
		else $error("ram_ack without outstanding access");

endmodule

/* hdl/uparc_lsu_pkg.sv */
package uparc_lsu_pkg;

	// load/store command as seen on lsu_cmd and i_lsu_op
	typedef enum logic [1:0] {
		LSU_IDLE	= 2'b00,	// no access
		LSU_BYTE	= 2'b01,	// 8-bit access
		LSU_HWORD	= 2'b10,	// 16-bit access, bit 0 of address must be clear
		LSU_WORD	= 2'b11		// 32-bit access, low two address bits must be clear
	} lsu_cmd_t;

	// writeback result select, bit 3 marks a memory load
	typedef enum logic [3:0] {
		RD_ALU		= 4'b0000,	// pass ALU result
		RD_BYTE_SE	= 4'b1000,	// sign-extended byte
		RD_BYTE_ZE	= 4'b1001,	// zero-extended byte
		RD_HWORD_SE	= 4'b1010,	// sign-extended halfword
		RD_HWORD_ZE	= 4'b1011,	// zero-extended halfword
		RD_WORD		= 4'b1100	// full word
	} rd_mux_t;

endpackage

/* hdl/uparc_mem_subsys.sv */
module uparc_mem_subsys #(
	parameter int RAM_WORDS = 256,		// data memory depth in words
	parameter int WAIT_STATES = 2		// memory wait states per access
) (
	input  logic					clk,
	input  logic					nrst,
	input  logic					i_exec_stall,
	input  logic					i_fetch_stall,
	input  logic					i_nullify,
	output logic					o_mem_stall,
	output logic					o_bus_error,
	output logic					o_addr_error,
	input  logic [uparc_cfg_pkg::REGNO_WIDTH-1:0]	i_rd_no,
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	i_alu_result,
	input  uparc_lsu_pkg::lsu_cmd_t			i_lsu_op,
	input  logic					i_lsu_lns,
	input  logic					i_lsu_ext,
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	i_mem_data,
	output logic [uparc_cfg_pkg::REGNO_WIDTH-1:0]	o_rd_no,
	output logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	o_rd_val
);
	import uparc_cfg_pkg::*;
	import uparc_lsu_pkg::*;

	// stage to load/store unit
	logic [ADDR_WIDTH-1:0]		lsu_addr;
	logic [DATA_WIDTH-1:0]		lsu_wdata;
	lsu_cmd_t			lsu_cmd;
	logic				lsu_rnw;
	logic [DATA_WIDTH-1:0]		lsu_rdata;
	logic				lsu_busy;
	logic				lsu_err_align;
	logic				lsu_err_bus;

	// load/store unit to memory
	logic				ram_req;
	logic				ram_we;
	logic [WORD_ADDR_WIDTH-1:0]	ram_addr;
	logic [BYTE_LANES-1:0]		ram_be;
	logic [DATA_WIDTH-1:0]		ram_wdata;
	logic				ram_ack;
	logic [DATA_WIDTH-1:0]		ram_rdata;
	logic				ram_err;

	uparc_memory_access mem0 (.*);		// pipeline stage

	uparc_lsu lsu0 (.*);			// alignment and lane steering

	uparc_data_ram #(
		.RAM_WORDS	(RAM_WORDS),
		.WAIT_STATES	(WAIT_STATES)
	) ram0 (.*);				// backing store

endmodule

/* hdl/uparc_memory_access.sv */
module uparc_memory_access (
	input  logic					clk,
	input  logic					nrst,
	input  logic					i_exec_stall,		// execute stage holds
	input  logic					i_fetch_stall,		// fetch stage holds
	input  logic					i_nullify,		// kill the incoming item
	output logic					o_mem_stall,		// access in progress
	output logic					o_bus_error,		// bus error on held item
	output logic					o_addr_error,		// misaligned held item
	input  logic [uparc_cfg_pkg::REGNO_WIDTH-1:0]	i_rd_no,
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	i_alu_result,		// result or effective address
	input  uparc_lsu_pkg::lsu_cmd_t			i_lsu_op,
	input  logic					i_lsu_lns,		// 1 load, 0 store
	input  logic					i_lsu_ext,		// 1 sign extend
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	i_mem_data,		// store data
	output logic [uparc_cfg_pkg::ADDR_WIDTH-1:0]	lsu_addr,
	output logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	lsu_wdata,
	output uparc_lsu_pkg::lsu_cmd_t			lsu_cmd,
	output logic					lsu_rnw,
	input  logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	lsu_rdata,
	input  logic					lsu_busy,
	input  logic					lsu_err_align,
	input  logic					lsu_err_bus,
	output logic [uparc_cfg_pkg::REGNO_WIDTH-1:0]	o_rd_no,
	output logic [uparc_cfg_pkg::DATA_WIDTH-1:0]	o_rd_val
);
	import uparc_cfg_pkg::*;
	import uparc_lsu_pkg::*;

	logic				core_stall;	// any stall source freezes the stage
	logic				err_bus_r;	// sticky bus error
	logic				err_align_r;	// sticky alignment error
	rd_mux_t			rd_mux_r;	// result select of held item
	rd_mux_t			rd_mux_nxt;
	logic [DATA_WIDTH-1:0]		alu_r;		// ALU result or address of held item

	// hold the pipe in the command cycle too, so an alignment error
	// that shows up a cycle later still belongs to the held item
	assign o_mem_stall = lsu_busy | (lsu_cmd != LSU_IDLE);
	assign core_stall = i_exec_stall | i_fetch_stall | o_mem_stall;

	assign o_bus_error = lsu_err_bus | err_bus_r;		// pulse or remembered
	assign o_addr_error = lsu_err_align | err_align_r;

	assign lsu_addr = alu_r;				// effective address of the access

	// pick the writeback source for the incoming item
	always_comb
	begin
		rd_mux_nxt = RD_ALU;				// stores and ALU ops
		if (!i_nullify && i_lsu_lns)
		begin
			case (i_lsu_op)
			LSU_BYTE:  rd_mux_nxt = i_lsu_ext ? RD_BYTE_SE : RD_BYTE_ZE;
			LSU_HWORD: rd_mux_nxt = i_lsu_ext ? RD_HWORD_SE : RD_HWORD_ZE;
			LSU_WORD:  rd_mux_nxt = RD_WORD;
			default:   rd_mux_nxt = RD_ALU;
			endcase
		end
	end

	// control state of the stage
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			lsu_cmd <= LSU_IDLE;
			lsu_rnw <= 1'b0;
			rd_mux_r <= RD_ALU;
			o_rd_no <= '0;
			err_bus_r <= 1'b0;
			err_align_r <= 1'b0;
		end
		else
		begin
			lsu_cmd <= LSU_IDLE;				// command is a single pulse
			err_bus_r <= err_bus_r | lsu_err_bus;		// remember while held
			err_align_r <= err_align_r | lsu_err_align;
			if (!core_stall)
			begin
				o_rd_no <= i_nullify ? '0 : i_rd_no;	// nullified item writes r0
				lsu_cmd <= i_nullify ? LSU_IDLE : i_lsu_op;
				lsu_rnw <= i_lsu_lns;
				rd_mux_r <= rd_mux_nxt;
				err_bus_r <= 1'b0;			// new item starts clean
				err_align_r <= 1'b0;
			end
		end
	end

	// payload of the held item
	always_ff @(posedge clk)
	begin
		if (!core_stall)
		begin
			alu_r <= i_alu_result;
			lsu_wdata <= i_mem_data;
		end
	end

	// writeback value, load data is already shifted to bit 0
	always_comb
	begin
		case (rd_mux_r)
		RD_BYTE_SE:  o_rd_val = {{(DATA_WIDTH-BYTE_BITS){lsu_rdata[BYTE_BITS-1]}},
				lsu_rdata[BYTE_BITS-1:0]};
		RD_BYTE_ZE:  o_rd_val = {{(DATA_WIDTH-BYTE_BITS){1'b0}}, lsu_rdata[BYTE_BITS-1:0]};
		RD_HWORD_SE: o_rd_val = {{(DATA_WIDTH-HWORD_BITS){lsu_rdata[HWORD_BITS-1]}},
				lsu_rdata[HWORD_BITS-1:0]};
		RD_HWORD_ZE: o_rd_val = {{(DATA_WIDTH-HWORD_BITS){1'b0}}, lsu_rdata[HWORD_BITS-1:0]};
		RD_WORD:     o_rd_val = lsu_rdata;
		default:     o_rd_val = alu_r;
		endcase
	end

	// a stalled edge never launches a new access
	a_no_cmd_after_stall: assert property (@(posedge clk) disable iff (!nrst)
		o_mem_stall |=> lsu_cmd == LSU_IDLE)
		else $error("command issued after a memory stall cycle");

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f verilog.f
./obj_dir/Vtb_mem_subsys > sim.log 2>&1 || true
cat sim.log
if grep -q "Test completed successfully" sim.log; then
	exit 0
fi
exit 1

/* verilog.f */
hdl/uparc_cfg_pkg.sv
hdl/uparc_lsu_pkg.sv
hdl/uparc_memory_access.sv
hdl/uparc_lsu.sv
hdl/uparc_data_ram.sv
hdl/uparc_mem_subsys.sv
dv/mem_checker.sv
dv/tb_mem_subsys.sv
